// ==== hw/histo_pkg.sv ====
// histogram adapter shared definitions
package histo_pkg;

    localparam int WORD_BITS = 32;
    localparam int PIXEL_BITS = 8;
    localparam int PIXELS_PER_WORD = 4;

    // frame length field of a header word
    localparam int LEN_BITS = 16;

    // one input word, read either as a header or as four pixels
    typedef union packed {
        struct packed {
            logic [WORD_BITS-LEN_BITS-1:0] unused; // ignored
            logic [LEN_BITS-1:0] length;           // frame length in words
        } header;
        logic [PIXELS_PER_WORD-1:0][PIXEL_BITS-1:0] pixels; // pixel 0 in the low byte
    } in_word_u;

endpackage

// ==== hw/frame_parser.sv ====
// length-prefixed frame parser
module frame_parser import histo_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,

    input  in_word_u             in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    output logic [WORD_BITS-1:0] word_data,
    output logic                 word_valid,
    output logic                 word_last,
    input  logic                 word_ready
);

    logic [LEN_BITS-1:0] remaining_q; // pixel words still due in this frame
    logic in_header;

    assign in_header = (remaining_q == '0);

    // headers are always consumed, pixel words only when downstream takes them
    assign in_ready = in_header || word_ready;

    assign word_data = in_data;
    assign word_valid = in_valid && !in_header;
    assign word_last = (remaining_q == LEN_BITS'(1));

    always_ff @(posedge clock) begin
        if (reset) begin
            remaining_q <= '0;
        end else if (in_valid && in_ready) begin
            if (in_header) begin
                remaining_q <= in_data.header.length; // zero header leaves us idle
            end else begin
                remaining_q <= remaining_q - LEN_BITS'(1);
            end
        end
    end

endmodule

// ==== hw/pixel_unpacker.sv ====
// word to pixel unpacker
module pixel_unpacker import histo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,

    input  in_word_u              word_data,
    input  logic                  word_valid,
    input  logic                  word_last,
    output logic                  word_ready,

    output logic [PIXEL_BITS-1:0] pix_data,
    output logic                  pix_valid,
    output logic                  pix_last,
    input  logic                  pix_ready
);

    localparam int IDX_BITS = $clog2(PIXELS_PER_WORD);
    localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(PIXELS_PER_WORD - 1);

    in_word_u buf_q;
    logic full_q;
    logic last_q; // buffered word ends the frame
    logic [IDX_BITS-1:0] idx_q;
    logic pix_take;

    assign pix_take = pix_valid && pix_ready;

    // refill in the same cycle the final pixel leaves
    assign word_ready = !full_q || (idx_q == LAST_IDX && pix_ready);

    assign pix_valid = full_q;
    assign pix_data = buf_q.pixels[idx_q];
    assign pix_last = full_q && last_q && (idx_q == LAST_IDX);

    always_ff @(posedge clock) begin
        if (reset) begin
            full_q <= 1'b0;
            last_q <= 1'b0;
            idx_q <= '0;
        end else begin
            if (pix_take) begin
                idx_q <= idx_q + IDX_BITS'(1);
                if (idx_q == LAST_IDX) full_q <= 1'b0;
            end
            if (word_valid && word_ready) begin // wins over the drain above
                full_q <= 1'b1;
                last_q <= word_last;
                idx_q <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_valid && word_ready) buf_q <= word_data;
    end

endmodule

// ==== hw/histogram_engine.sv ====
// per-frame intensity histogram
module histogram_engine import histo_pkg::*; #(
    parameter int MAX_FRAME_WORDS = 1024,
    parameter int N_BINS = 8,
    localparam int CNT_W = $clog2(MAX_FRAME_WORDS * PIXELS_PER_WORD + 1)
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic [PIXEL_BITS-1:0] pix_data,
    input  logic                  pix_valid,
    input  logic                  pix_last,
    output logic                  pix_ready,

    output logic [CNT_W-1:0]      snap_counts [N_BINS],
    output logic                  snap_valid,
    input  logic                  snap_ready
);

    localparam int BIN_BITS = $clog2(N_BINS);

    logic [CNT_W-1:0] bins_q [N_BINS];
    logic [CNT_W-1:0] snap_q [N_BINS];
    logic snap_valid_q;
    logic [BIN_BITS-1:0] sel;
    logic pix_take;

    assign sel = pix_data[PIXEL_BITS-1 -: BIN_BITS]; // top bits pick the bin
    assign pix_take = pix_valid && pix_ready;

    // stall only while an untaken snapshot is waiting
    assign pix_ready = !snap_valid_q || snap_ready;

    assign snap_valid = snap_valid_q;
    assign snap_counts = snap_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            snap_valid_q <= 1'b0;
            for (int i = 0; i < N_BINS; i++) begin
                bins_q[i] <= '0;
            end
        end else begin
            if (snap_valid_q && snap_ready) snap_valid_q <= 1'b0;
            if (pix_take) begin
                if (pix_last) begin
                    snap_valid_q <= 1'b1;
                    for (int i = 0; i < N_BINS; i++) begin
                        bins_q[i] <= '0; // start the next frame fresh
                    end
                end else begin
                    bins_q[sel] <= bins_q[sel] + CNT_W'(1);
                end
            end
        end
    end

    // snapshot includes the last pixel itself
    always_ff @(posedge clock) begin
        if (pix_take && pix_last) begin
            for (int i = 0; i < N_BINS; i++) begin
                snap_q[i] <= bins_q[i] + CNT_W'(sel == BIN_BITS'(i));
            end
        end
    end

endmodule

// ==== hw/result_serializer.sv ====
// bin count serializer
module result_serializer import histo_pkg::*; #(
    parameter int MAX_FRAME_WORDS = 1024,
    parameter int N_BINS = 8,
    localparam int CNT_W = $clog2(MAX_FRAME_WORDS * PIXELS_PER_WORD + 1)
) (
    input  logic                 clock,
    input  logic                 reset,

    input  logic [CNT_W-1:0]     snap_counts [N_BINS],
    input  logic                 snap_valid,
    output logic                 snap_ready,

    output logic [WORD_BITS-1:0] out_data,
    output logic                 out_valid,
    output logic                 out_last,
    input  logic                 downstream_stall
);

    localparam int BIN_BITS = $clog2(N_BINS);
    localparam logic [BIN_BITS-1:0] LAST_BIN = BIN_BITS'(N_BINS - 1);

    logic [CNT_W-1:0] buf_q [N_BINS];
    logic busy_q;
    logic [BIN_BITS-1:0] idx_q;

    assign snap_ready = !busy_q;

    assign out_valid = busy_q;
    assign out_data = {{(WORD_BITS - CNT_W){1'b0}}, buf_q[idx_q]};
    assign out_last = busy_q && (idx_q == LAST_BIN);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= 1'b0;
            idx_q <= '0;
        end else if (!busy_q) begin
            if (snap_valid) begin
                busy_q <= 1'b1;
                idx_q <= '0;
            end
        end else if (!downstream_stall) begin
            idx_q <= idx_q + BIN_BITS'(1);
            if (idx_q == LAST_BIN) begin
                busy_q <= 1'b0; // idle again, next snapshot a cycle later
                idx_q <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!busy_q && snap_valid) buf_q <= snap_counts;
    end

endmodule

// ==== hw/histo_top.sv ====
// histogram adapter top level
module histo_top import histo_pkg::*; #(
    parameter int MAX_FRAME_WORDS = 1024,
    parameter int N_BINS = 8
) (
    input  logic                 clock,
    input  logic                 reset,

    input  logic [WORD_BITS-1:0] in_data,
    input  logic                 in_valid,
    output logic                 upstream_stall,

    output logic [WORD_BITS-1:0] out_data,
    output logic                 out_valid,
    output logic                 out_last,
    input  logic                 downstream_stall
);

    localparam int CNT_W = $clog2(MAX_FRAME_WORDS * PIXELS_PER_WORD + 1);

    logic in_ready;

    logic [WORD_BITS-1:0] word_data;
    logic word_valid;
    logic word_last;
    logic word_ready;

    logic [PIXEL_BITS-1:0] pix_data;
    logic pix_valid;
    logic pix_last;
    logic pix_ready;

    logic [CNT_W-1:0] snap_counts [N_BINS];
    logic snap_valid;
    logic snap_ready;

    assign upstream_stall = !in_ready;

    frame_parser parser (
        .clock(clock), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .word_data(word_data), .word_valid(word_valid),
        .word_last(word_last), .word_ready(word_ready)
    );

    pixel_unpacker unpacker (
        .clock(clock), .reset(reset),
        .word_data(word_data), .word_valid(word_valid),
        .word_last(word_last), .word_ready(word_ready),
        .pix_data(pix_data), .pix_valid(pix_valid),
        .pix_last(pix_last), .pix_ready(pix_ready)
    );

    histogram_engine #(.MAX_FRAME_WORDS(MAX_FRAME_WORDS), .N_BINS(N_BINS)) engine (
        .clock(clock), .reset(reset),
        .pix_data(pix_data), .pix_valid(pix_valid),
        .pix_last(pix_last), .pix_ready(pix_ready),
        .snap_counts(snap_counts), .snap_valid(snap_valid), .snap_ready(snap_ready)
    );

    result_serializer #(.MAX_FRAME_WORDS(MAX_FRAME_WORDS), .N_BINS(N_BINS)) serializer (
        .clock(clock), .reset(reset),
        .snap_counts(snap_counts), .snap_valid(snap_valid), .snap_ready(snap_ready),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .downstream_stall(downstream_stall)
    );

endmodule

// ==== tests/histo_vectors.svh ====
// histogram test frames
`ifndef HISTO_VECTORS_SVH
`define HISTO_VECTORS_SVH

// each entry is a name, a header word, pixel words with unused slots zero and the bin counts
// bins follow the top three bits of each pixel, pixel 0 in the low byte

localparam int N_VEC = 6;
localparam int MAX_WORDS = 8;

string vec_name [N_VEC] = '{
    "single", "pair_a", "pair_b", "zero_len", "after_zero", "full"
};

logic [31:0] vec_header [N_VEC] = '{
    32'h0000_0001, 32'h0000_0002, 32'h0000_0001,
    32'h0000_0000, 32'hABCD_0001, 32'h0000_0008 // upper half of after_zero is junk
};

logic [31:0] vec_words [N_VEC][MAX_WORDS] = '{
    '{32'hFFE02000, 0, 0, 0, 0, 0, 0, 0},
    '{32'h10305070, 32'h90B0D0F0, 0, 0, 0, 0, 0, 0},
    '{32'h40404040, 0, 0, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{32'h7F3F1F00, 0, 0, 0, 0, 0, 0, 0},
    '{32'h00000000, 32'hFFFFFFFF, 32'h01234567, 32'h89ABCDEF,
      32'h3C3C3C3C, 32'h80808080, 32'h5F5F5F5F, 32'hC1C1C1C1}
};

int vec_bins [N_VEC][N_BINS] = '{
    '{1, 1, 0, 0, 0, 0, 0, 2},
    '{1, 1, 1, 1, 1, 1, 1, 1},
    '{0, 0, 4, 0, 0, 0, 0, 0},
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{2, 1, 0, 1, 0, 0, 0, 0},
    '{5, 5, 5, 1, 5, 1, 5, 5}
};

`endif

// ==== tests/histo_top_tb.sv ====
// histogram adapter testbench
module histo_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_BINS = 8;
    localparam int MAX_FRAME_WORDS = 1024;
    localparam int TIMEOUT = 1000;

    `include "histo_vectors.svh"

    logic clock;
    logic reset;
    logic [31:0] in_data;
    logic in_valid;
    logic upstream_stall;
    logic [31:0] out_data;
    logic out_valid;
    logic out_last;
    logic downstream_stall;

    logic stall_on;
    logic [7:0] lfsr;
    logic [31:0] got_data [$];
    bit got_last [$];

    histo_top #(.MAX_FRAME_WORDS(MAX_FRAME_WORDS), .N_BINS(N_BINS)) DUT (
        .clock(clock), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .upstream_stall(upstream_stall),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .downstream_stall(downstream_stall)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // hold the word until a cycle without upstream stall
    task automatic send_word(input logic [31:0] w);
        int cycles;
        cycles = 0;
        in_data = w;
        in_valid = 1'b1;
        @(negedge clock);
        while (upstream_stall) begin
            if (cycles == TIMEOUT) abort_run("timed out waiting for the input to accept a word");
            cycles++;
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic send_frame(input int v);
        int n;
        n = int'(vec_header[v][15:0]);
        send_word(vec_header[v]);
        for (int k = 0; k < n; k++) begin
            send_word(vec_words[v][k]);
        end
    endtask

    function automatic int expected_words();
        int n;
        n = 0;
        for (int v = 0; v < N_VEC; v++) begin
            if (vec_header[v][15:0] != 16'd0) n += N_BINS; // zero header yields nothing
        end
        return n;
    endfunction

    task automatic wait_for_results(input int n);
        int cycles;
        cycles = 0;
        while (got_data.size() < n) begin
            if (cycles == TIMEOUT) abort_run("timed out waiting for result");
            cycles++;
            @(posedge clock);
        end
        repeat (4 * N_BINS) @(posedge clock); // room for any extra word
        check_value("result word count", n, got_data.size());
    endtask

    task automatic check_results(input int pass);
        int w;
        int sum;
        w = 0;
        for (int v = 0; v < N_VEC; v++) begin
            if (vec_header[v][15:0] != 16'd0) begin
                sum = 0;
                for (int b = 0; b < N_BINS; b++) begin
                    check_value($sformatf("%s pass %0d bin %0d", vec_name[v], pass, b),
                                vec_bins[v][b], got_data[w]);
                    check_value($sformatf("%s pass %0d last %0d", vec_name[v], pass, b),
                                32'(b == N_BINS - 1), 32'(got_last[w]));
                    sum += got_data[w];
                    w++;
                end
                check_value($sformatf("%s pass %0d pixel sum", vec_name[v], pass),
                            4 * vec_header[v][15:0], sum);
            end
        end
    endtask

    // random back-pressure on the output
    initial begin
        downstream_stall = 1'b0;
        lfsr = 8'd37;
        forever begin
            @(posedge clock);
            #1;
            if (stall_on) begin
                lfsr = lfsr_step(lfsr);
                downstream_stall = lfsr[0];
            end else begin
                downstream_stall = 1'b0;
            end
        end
    end

    // collector samples mid cycle
    initial begin
        forever begin
            @(negedge clock);
            if (out_valid && !downstream_stall) begin
                got_data.push_back(out_data);
                got_last.push_back(out_last);
            end
        end
    end

    initial begin
        reset = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        stall_on = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_value("reset out_valid", 0, 32'(out_valid));
        check_value("reset upstream_stall", 0, 32'(upstream_stall));

        // pass 0 runs clean, pass 1 under random stalls
        for (int pass = 0; pass < 2; pass++) begin
            stall_on = (pass == 1);
            @(posedge clock);
            #1;
            for (int v = 0; v < N_VEC; v++) begin
                send_frame(v); // frames back to back
            end
            in_valid = 1'b0;
            in_data = '0;
            wait_for_results(expected_words());
            check_results(pass);
            got_data.delete();
            got_last.delete();
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+tests
hw/histo_pkg.sv
hw/frame_parser.sv
hw/pixel_unpacker.sv
hw/histogram_engine.sv
hw/result_serializer.sv
hw/histo_top.sv
tests/histo_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILE_LIST ?= src.f
TB_TOP    ?= histo_top_tb
RTL_TOP   ?= histo_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
